//--- src/mips_pkg.sv
package mips_pkg;

   localparam int word_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   // opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_sw    = 6'h2b;

   // funct field of r-type
   localparam logic [5:0] fn_add = 6'h20;
   localparam logic [5:0] fn_sub = 6'h22;
   localparam logic [5:0] fn_and = 6'h24;
   localparam logic [5:0] fn_or  = 6'h25;
   localparam logic [5:0] fn_slt = 6'h2a;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt
   } alu_op_t;

   typedef struct packed {
      logic              valid;
      logic [word_w-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic                  alu_src;
      alu_op_t               alu_op;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [reg_addr_w-1:0] dest;
      logic [word_w-1:0]     rdata_1;
      logic [word_w-1:0]     rdata_2;
      logic [word_w-1:0]     imm;
   } id_ex_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic [reg_addr_w-1:0] dest;
      logic [word_w-1:0]     alu_result;
      logic [word_w-1:0]     store_data;
   } ex_mem_t;

   // result on its way into the register file
   typedef struct packed {
      logic                  reg_write;
      logic [reg_addr_w-1:0] dest;
      logic [word_w-1:0]     value;
   } wb_t;

endpackage

//--- src/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
   parameter int addr_w = 9
) (
   input  logic                        clk,
   input  logic                        en,
   input  logic [addr_w-1:0]           addr,
   input  logic                        wen,
   input  logic [mips_pkg::word_w-1:0] wdata,
   output logic [mips_pkg::word_w-1:0] rdata,
   input  logic [addr_w-1:0]           ext_addr,
   input  logic                        ext_wen,
   input  logic                        ext_ren,
   input  logic [mips_pkg::word_w-1:0] ext_wdata,
   output logic [mips_pkg::word_w-1:0] ext_rdata
);

   logic [mips_pkg::word_w-1:0] mem [2**addr_w];

   always_ff @(posedge clk) begin
      // core port
      if (wen) begin
         mem[addr] <= wdata;
      end
      if (en) begin
         rdata <= mem[addr];
      end
      // external port is only active while the core is halted
      if (ext_wen) begin
         mem[ext_addr] <= ext_wdata;
      end
      if (ext_ren) begin
         ext_rdata <= mem[ext_addr];
      end
   end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             enable,
   input  logic                             stall,
   input  logic [mips_pkg::imem_addr_w-1:0] imem_addr,
   input  logic                             imem_wen,
   input  logic [mips_pkg::word_w-1:0]      imem_wdata,
   output mips_pkg::if_id_t                 if_id
);

   logic [mips_pkg::imem_addr_w-1:0] pc;
   logic                             advance;
   logic                             valid;
   logic [mips_pkg::word_w-1:0]      instr;

   // a stalled word stays in the ram output register
   assign advance = enable && !stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc    <= '0;
         valid <= 1'b0;
      end else if (advance) begin
         pc    <= pc + 1'b1;
         valid <= 1'b1;
      end
   end

   word_ram #(
      .addr_w(mips_pkg::imem_addr_w)
   ) imem (
      .clk      (clk),
      .en       (advance),
      .addr     (pc),
      .wen      (1'b0),
      .wdata    ('0),
      .rdata    (instr),
      .ext_addr (imem_addr),
      .ext_wen  (imem_wen),
      .ext_ren  (1'b0),
      .ext_wdata(imem_wdata),
      .ext_rdata()
   );

   assign if_id.valid = valid;
   assign if_id.instr = instr;

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic             clk,
   input  logic             reset,
   input  logic             enable,
   input  mips_pkg::if_id_t if_id,
   input  mips_pkg::wb_t    wb,
   output logic             stall,
   output mips_pkg::id_ex_t id_ex
);

   logic [5:0]                      opcode;
   logic [5:0]                      funct;
   logic [mips_pkg::reg_addr_w-1:0] rs;
   logic [mips_pkg::reg_addr_w-1:0] rt;
   logic [mips_pkg::reg_addr_w-1:0] rd;
   logic [mips_pkg::word_w-1:0]     regs [2**mips_pkg::reg_addr_w];
   logic [mips_pkg::word_w-1:0]     rdata_1;
   logic [mips_pkg::word_w-1:0]     rdata_2;
   mips_pkg::id_ex_t                id_next;

   assign opcode = if_id.instr[31:26];
   assign rs     = if_id.instr[25:21];
   assign rt     = if_id.instr[20:16];
   assign rd     = if_id.instr[15:11];
   assign funct  = if_id.instr[5:0];

   // register file, r0 is never written
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) begin
            regs[i] <= '0;
         end
      end else if (enable && wb.reg_write && wb.dest != '0) begin
         regs[wb.dest] <= wb.value;
      end
   end

   // write-through so a same-cycle writeback is seen
   assign rdata_1 = (rs == '0) ? '0 :
                    (wb.reg_write && wb.dest == rs) ? wb.value : regs[rs];
   assign rdata_2 = (rt == '0) ? '0 :
                    (wb.reg_write && wb.dest == rt) ? wb.value : regs[rt];

   // load in EX whose target is needed right now
   assign stall = id_ex.mem_read && (id_ex.rt != '0) && if_id.valid &&
                  (id_ex.rt == rs || id_ex.rt == rt);

   always_comb begin
      id_next         = '0;
      id_next.rs      = rs;
      id_next.rt      = rt;
      id_next.dest    = rt;
      id_next.rdata_1 = rdata_1;
      id_next.rdata_2 = rdata_2;
      id_next.imm     = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
      id_next.alu_op  = mips_pkg::alu_add;
      if (if_id.valid && !stall) begin
         case (opcode)
            mips_pkg::op_rtype: begin
               id_next.dest      = rd;
               id_next.reg_write = 1'b1;
               case (funct)
                  mips_pkg::fn_add: id_next.alu_op = mips_pkg::alu_add;
                  mips_pkg::fn_sub: id_next.alu_op = mips_pkg::alu_sub;
                  mips_pkg::fn_and: id_next.alu_op = mips_pkg::alu_and;
                  mips_pkg::fn_or:  id_next.alu_op = mips_pkg::alu_or;
                  mips_pkg::fn_slt: id_next.alu_op = mips_pkg::alu_slt;
                  // includes the all-zero no-op
                  default:          id_next.reg_write = 1'b0;
               endcase
            end
            mips_pkg::op_addi: begin
               id_next.reg_write = 1'b1;
               id_next.alu_src   = 1'b1;
            end
            mips_pkg::op_lw: begin
               id_next.reg_write = 1'b1;
               id_next.mem_read  = 1'b1;
               id_next.alu_src   = 1'b1;
            end
            mips_pkg::op_sw: begin
               id_next.mem_write = 1'b1;
               id_next.alu_src   = 1'b1;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex.reg_write <= 1'b0;
         id_ex.mem_read  <= 1'b0;
         id_ex.mem_write <= 1'b0;
         id_ex.alu_src   <= 1'b0;
      end else if (enable) begin
         id_ex <= id_next;
      end
   end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  logic              clk,
   input  logic              reset,
   input  logic              enable,
   input  mips_pkg::id_ex_t  id_ex,
   input  mips_pkg::wb_t     wb,
   output mips_pkg::ex_mem_t ex_mem
);

   logic [mips_pkg::word_w-1:0] op_rs;
   logic [mips_pkg::word_w-1:0] op_rt;
   logic [mips_pkg::word_w-1:0] alu_b;
   logic [mips_pkg::word_w-1:0] alu_result;

   // nearest producer wins, then the register read
   function automatic logic [mips_pkg::word_w-1:0] forward(
      input logic [mips_pkg::reg_addr_w-1:0] src,
      input logic [mips_pkg::word_w-1:0]     reg_value,
      input mips_pkg::ex_mem_t               em,
      input mips_pkg::wb_t                   w
   );
      if (em.reg_write && em.dest != '0 && em.dest == src) begin
         return em.alu_result;
      end
      if (w.reg_write && w.dest != '0 && w.dest == src) begin
         return w.value;
      end
      return reg_value;
   endfunction

   assign op_rs = forward(id_ex.rs, id_ex.rdata_1, ex_mem, wb);
   assign op_rt = forward(id_ex.rt, id_ex.rdata_2, ex_mem, wb);
   assign alu_b = id_ex.alu_src ? id_ex.imm : op_rt;

   always_comb begin
      case (id_ex.alu_op)
         mips_pkg::alu_add: alu_result = op_rs + alu_b;
         mips_pkg::alu_sub: alu_result = op_rs - alu_b;
         mips_pkg::alu_and: alu_result = op_rs & alu_b;
         mips_pkg::alu_or:  alu_result = op_rs | alu_b;
         // signed compare
         mips_pkg::alu_slt: begin
            alu_result = {{(mips_pkg::word_w-1){1'b0}}, $signed(op_rs) < $signed(alu_b)};
         end
         default:           alu_result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem.reg_write <= 1'b0;
         ex_mem.mem_read  <= 1'b0;
         ex_mem.mem_write <= 1'b0;
      end else if (enable) begin
         ex_mem.reg_write  <= id_ex.reg_write;
         ex_mem.mem_read   <= id_ex.mem_read;
         ex_mem.mem_write  <= id_ex.mem_write;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.alu_result <= alu_result;
         ex_mem.store_data <= op_rt;
      end
   end

endmodule

//--- src/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             enable,
   input  mips_pkg::ex_mem_t                ex_mem,
   input  logic [mips_pkg::dmem_addr_w-1:0] dmem_addr,
   input  logic                             dmem_wen,
   input  logic                             dmem_ren,
   input  logic [mips_pkg::word_w-1:0]      dmem_wdata,
   output logic [mips_pkg::word_w-1:0]      dmem_rdata,
   output mips_pkg::wb_t                    wb
);

   logic [mips_pkg::word_w-1:0]     load_data;
   logic                            wb_reg_write;
   logic                            wb_from_mem;
   logic [mips_pkg::reg_addr_w-1:0] wb_dest;
   logic [mips_pkg::word_w-1:0]     wb_alu;

   // byte address from the alu, memory is word indexed
   word_ram #(
      .addr_w(mips_pkg::dmem_addr_w)
   ) dmem (
      .clk      (clk),
      .en       (enable && ex_mem.mem_read),
      .addr     (ex_mem.alu_result[11:2]),
      .wen      (enable && ex_mem.mem_write),
      .wdata    (ex_mem.store_data),
      .rdata    (load_data),
      .ext_addr (dmem_addr),
      .ext_wen  (dmem_wen),
      .ext_ren  (dmem_ren),
      .ext_wdata(dmem_wdata),
      .ext_rdata(dmem_rdata)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_reg_write <= 1'b0;
         wb_from_mem  <= 1'b0;
      end else if (enable) begin
         wb_reg_write <= ex_mem.reg_write;
         wb_from_mem  <= ex_mem.mem_read;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_dest <= ex_mem.dest;
         wb_alu  <= ex_mem.alu_result;
      end
   end

   assign wb.reg_write = wb_reg_write;
   assign wb.dest      = wb_dest;
   assign wb.value     = wb_from_mem ? load_data : wb_alu;

endmodule

//--- src/mips_core.sv
`timescale 1ns/1ps

module mips_core (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             enable,
   input  logic [mips_pkg::imem_addr_w-1:0] imem_addr,
   input  logic                             imem_wen,
   input  logic [mips_pkg::word_w-1:0]      imem_wdata,
   input  logic [mips_pkg::dmem_addr_w-1:0] dmem_addr,
   input  logic                             dmem_wen,
   input  logic                             dmem_ren,
   input  logic [mips_pkg::word_w-1:0]      dmem_wdata,
   output logic [mips_pkg::word_w-1:0]      dmem_rdata
);

   mips_pkg::if_id_t  if_id;
   mips_pkg::id_ex_t  id_ex;
   mips_pkg::ex_mem_t ex_mem;
   mips_pkg::wb_t     wb;
   logic              stall;

   fetch_stage u_fetch (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .stall     (stall),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_wdata(imem_wdata),
      .if_id     (if_id)
   );

   decode_stage u_decode (
      .clk   (clk),
      .reset (reset),
      .enable(enable),
      .if_id (if_id),
      .wb    (wb),
      .stall (stall),
      .id_ex (id_ex)
   );

   execute_stage u_execute (
      .clk   (clk),
      .reset (reset),
      .enable(enable),
      .id_ex (id_ex),
      .wb    (wb),
      .ex_mem(ex_mem)
   );

   memory_writeback u_mem_wb (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .ex_mem    (ex_mem),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata),
      .wb        (wb)
   );

endmodule

//--- include/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

typedef logic [mips_pkg::word_w-1:0] ref_word_t;
typedef ref_word_t ref_image_t [1024];
typedef ref_word_t ref_prog_t [$];

function automatic ref_word_t enc_r(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
   return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic ref_word_t enc_i(input logic [5:0] op, input logic [4:0] rt, rs,
                                    input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic ref_word_t enc_add(input logic [4:0] rd, rs, rt);
   return enc_r(mips_pkg::fn_add, rd, rs, rt);
endfunction

function automatic ref_word_t enc_sub(input logic [4:0] rd, rs, rt);
   return enc_r(mips_pkg::fn_sub, rd, rs, rt);
endfunction

function automatic ref_word_t enc_and(input logic [4:0] rd, rs, rt);
   return enc_r(mips_pkg::fn_and, rd, rs, rt);
endfunction

function automatic ref_word_t enc_or(input logic [4:0] rd, rs, rt);
   return enc_r(mips_pkg::fn_or, rd, rs, rt);
endfunction

function automatic ref_word_t enc_slt(input logic [4:0] rd, rs, rt);
   return enc_r(mips_pkg::fn_slt, rd, rs, rt);
endfunction

function automatic ref_word_t enc_addi(input logic [4:0] rt, rs, input logic [15:0] imm);
   return enc_i(mips_pkg::op_addi, rt, rs, imm);
endfunction

function automatic ref_word_t enc_lw(input logic [4:0] rt, base, input logic [15:0] off);
   return enc_i(mips_pkg::op_lw, rt, base, off);
endfunction

function automatic ref_word_t enc_sw(input logic [4:0] rt, base, input logic [15:0] off);
   return enc_i(mips_pkg::op_sw, rt, base, off);
endfunction

function automatic ref_word_t enc_nop();
   return '0;
endfunction

// runs the program in order and returns the final data memory
function automatic ref_image_t ref_run(input ref_prog_t prog, input ref_image_t init);
   ref_word_t  regs [32];
   ref_image_t mem;
   ref_word_t  instr;
   ref_word_t  a;
   ref_word_t  b;
   ref_word_t  imm;
   ref_word_t  addr;
   ref_word_t  res;
   logic [4:0] dest;
   logic       wr;
   mem = init;
   foreach (regs[i]) begin
      regs[i] = '0;
   end
   foreach (prog[i]) begin
      instr = prog[i];
      a     = regs[instr[25:21]];
      b     = regs[instr[20:16]];
      imm   = {{16{instr[15]}}, instr[15:0]};
      addr  = a + imm;
      dest  = instr[20:16];
      res   = '0;
      wr    = 1'b0;
      case (instr[31:26])
         mips_pkg::op_rtype: begin
            dest = instr[15:11];
            wr   = 1'b1;
            case (instr[5:0])
               mips_pkg::fn_add: res = a + b;
               mips_pkg::fn_sub: res = a - b;
               mips_pkg::fn_and: res = a & b;
               mips_pkg::fn_or:  res = a | b;
               mips_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 1 : 0;
               default:          wr = 1'b0;
            endcase
         end
         mips_pkg::op_addi: begin
            res = addr;
            wr  = 1'b1;
         end
         mips_pkg::op_lw: begin
            res = mem[addr[11:2]];
            wr  = 1'b1;
         end
         mips_pkg::op_sw: mem[addr[11:2]] = b;
         default: ;
      endcase
      if (wr && dest != 5'd0) begin
         regs[dest] = res;
      end
   end
   return mem;
endfunction

`endif

//--- testbench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

   `include "mips_ref_model.svh"

   localparam int n_progs   = 8;
   localparam int mem_words = 1024;

   logic                             clk;
   logic                             reset;
   logic                             enable;
   logic [mips_pkg::imem_addr_w-1:0] imem_addr;
   logic                             imem_wen;
   logic [mips_pkg::word_w-1:0]      imem_wdata;
   logic [mips_pkg::dmem_addr_w-1:0] dmem_addr;
   logic                             dmem_wen;
   logic                             dmem_ren;
   logic [mips_pkg::word_w-1:0]      dmem_wdata;
   logic [mips_pkg::word_w-1:0]      dmem_rdata;

   ref_word_t                        progs [n_progs][$];
   ref_image_t                       expected;
   bit                               built = 1'b0;
   logic                             rd_valid_q = 1'b0;
   logic [mips_pkg::dmem_addr_w-1:0] rd_idx_q;
   int                               checked = 0;

   mips_core UUT (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_wdata(imem_wdata),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input ref_word_t exp_v, input ref_word_t act_v);
      if (act_v !== exp_v) begin
         $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // pattern covers all ten address bits and the program index
   function automatic ref_word_t fill_word(input int idx, input int p);
      return {idx[9:0], ~idx[9:0], p[3:0], 8'ha5};
   endfunction

   task automatic add_random_program(input int p);
      logic [4:0]  rd;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] off;
      for (int i = 0; i < 40; i++) begin
         rd  = $urandom_range(7, 0);
         rs  = $urandom_range(7, 0);
         rt  = $urandom_range(7, 0);
         off = $urandom_range(1023, 0) << 2;
         case ($urandom_range(7, 0))
            0: progs[p].push_back(enc_add(rd, rs, rt));
            1: progs[p].push_back(enc_sub(rd, rs, rt));
            2: progs[p].push_back(enc_and(rd, rs, rt));
            3: progs[p].push_back(enc_or(rd, rs, rt));
            4: progs[p].push_back(enc_slt(rd, rs, rt));
            5: progs[p].push_back(enc_addi(rd, rs, $urandom));
            6: progs[p].push_back(enc_lw(rd, 5'd0, off));
            default: progs[p].push_back(enc_sw(rt, 5'd0, off));
         endcase
      end
      repeat (5) progs[p].push_back(enc_nop());
   endtask

   task automatic build_programs();
      // dependent r-type chain, stores right behind producers
      progs[0] = '{enc_addi(1, 0, 5), enc_addi(2, 0, 9), enc_add(3, 1, 2),
                   enc_sub(4, 3, 1), enc_and(5, 4, 3), enc_or(6, 5, 4),
                   enc_slt(7, 5, 6), enc_sw(7, 0, 0), enc_add(3, 7, 6),
                   enc_sw(3, 0, 4), enc_sub(4, 1, 3), enc_sw(4, 0, 8),
                   enc_sw(5, 0, 12), enc_sw(6, 0, 16)};
      // distance two and three
      progs[1] = '{enc_addi(1, 0, 100), enc_addi(2, 0, -16'd3), enc_nop(),
                   enc_add(3, 1, 2), enc_nop(), enc_nop(), enc_sw(3, 0, 32),
                   enc_sub(4, 3, 1), enc_nop(), enc_sw(4, 0, 36), enc_or(5, 4, 3),
                   enc_nop(), enc_nop(), enc_and(6, 5, 1), enc_sw(5, 0, 40),
                   enc_sw(6, 0, 44)};
      // load followed by an immediate use
      progs[2] = '{enc_lw(1, 0, 0), enc_add(2, 1, 1), enc_lw(3, 0, 4),
                   enc_sub(4, 2, 3), enc_lw(5, 0, 8), enc_sw(5, 0, 64),
                   enc_sw(2, 0, 68), enc_sw(4, 0, 72), enc_lw(6, 0, 72),
                   enc_sw(6, 0, 76)};
      // signed values and writes to r0
      progs[3] = '{enc_addi(1, 0, -16'd5), enc_addi(2, 0, 3), enc_slt(3, 1, 2),
                   enc_slt(4, 2, 1), enc_addi(0, 0, 77), enc_add(5, 0, 1),
                   enc_add(0, 1, 2), enc_or(6, 0, 2), enc_sw(3, 0, 0),
                   enc_sw(4, 0, 4), enc_sw(5, 0, 8), enc_sw(6, 0, 12),
                   enc_addi(7, 1, 16'h8000), enc_slt(7, 7, 1), enc_sw(7, 0, 16),
                   enc_sw(0, 0, 20)};
      for (int p = 0; p < 4; p++) begin
         repeat (5) progs[p].push_back(enc_nop());
      end
      for (int p = 4; p < n_progs; p++) begin
         add_random_program(p);
      end
   endtask

   task automatic pulse_reset();
      reset = 1'b1;
      repeat (5) next_cycle();
      reset = 1'b0;
   endtask

   // program words, then no-ops past the furthest fetch
   task automatic load_program(input int p);
      int n;
      n = progs[p].size() * 2 + 16;
      for (int i = 0; i < n; i++) begin
         imem_wen   = 1'b1;
         imem_addr  = i;
         imem_wdata = (i < progs[p].size()) ? progs[p][i] : '0;
         next_cycle();
      end
      imem_wen = 1'b0;
   endtask

   task automatic fill_data_memory(input ref_image_t init);
      for (int i = 0; i < mem_words; i++) begin
         dmem_wen   = 1'b1;
         dmem_addr  = i;
         dmem_wdata = init[i];
         next_cycle();
      end
      dmem_wen = 1'b0;
   endtask

   task automatic run_program(input int run, input int drop_at, input int drop_len);
      enable = 1'b1;
      for (int c = 0; c < run; c++) begin
         if (c == drop_at) begin
            enable = 1'b0;
            repeat (drop_len) next_cycle();
            enable = 1'b1;
         end
         next_cycle();
      end
      enable = 1'b0;
   endtask

   task automatic read_back();
      for (int i = 0; i < mem_words; i++) begin
         dmem_ren  = 1'b1;
         dmem_addr = i;
         next_cycle();
      end
      dmem_ren = 1'b0;
      next_cycle();
   endtask

   // read data is valid the edge after dmem_ren, compared half a cycle later
   always @(posedge clk) begin
      rd_valid_q <= dmem_ren;
      rd_idx_q   <= dmem_addr;
   end

   always @(negedge clk) begin
      if (rd_valid_q === 1'b1) begin
         check_value($sformatf("dmem_rdata[%0d]", rd_idx_q), expected[rd_idx_q], dmem_rdata);
         checked++;
      end
   end

   initial begin
      longint limit;
      limit = 0;
      wait (built);
      foreach (progs[p]) begin
         limit += progs[p].size() * 4 + 2 * mem_words + 120;
      end
      #(limit * 8);
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $fatal(1);
   end

   initial begin
      int         run;
      int         drop_at;
      int         drop_len;
      ref_image_t init;
      reset      = 1'b1;
      enable     = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_wen   = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wdata = '0;
      void'($urandom(32'h4a4e));
      build_programs();
      built = 1'b1;
      for (int p = 0; p < n_progs; p++) begin
         pulse_reset();
         load_program(p);
         foreach (init[i]) begin
            init[i] = fill_word(i, p);
         end
         fill_data_memory(init);
         expected = ref_run(progs[p], init);
         run      = progs[p].size() * 2 + 10;
         drop_at  = -1;
         drop_len = 0;
         // last program pauses mid-run
         if (p == n_progs - 1) begin
            drop_at  = $urandom_range(run / 2, 5);
            drop_len = $urandom_range(10, 3);
         end
         run_program(run, drop_at, drop_len);
         read_back();
      end
      if (checked == n_progs * mem_words) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("readback incomplete: %0d of %0d words compared", checked,
                  n_progs * mem_words);
         $display("Verification failed");
         $fatal(1);
      end
   end

endmodule

//--- flist.f
+incdir+include
src/mips_pkg.sv
src/word_ram.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/mips_core.sv
testbench/tb_mips_core.sv
